/* hw/fdbk_pkg.sv */
package fdbk_pkg;

	typedef logic signed [17:0] iq_t;   // Cartesian component or magnitude
	typedef logic signed [18:0] ph_t;   // Phase, full turn is 2^19
	typedef logic [7:0] gain_t;         // Unsigned loop gain
	typedef logic [1:0] evt_t;          // Clamp event flags

	typedef enum logic {
		vectoring,                      // (x, y) to magnitude and phase
		rotation                        // (x, 0) turned by z
	} cordic_mode_t;

	typedef enum logic [1:0] {
		idle,
		run,
		scale
	} cordic_state_t;

	localparam int EVT_HI = 0;          // Drive clamped at lim_hi
	localparam int EVT_LO = 1;          // Drive clamped at lim_lo

	localparam iq_t INV_GAIN = 18'sd79594;  // 1/K in Q0.17, K about 1.6468
	localparam ph_t HALF_TURN = 19'h40000;

	// atan(2^-i) scaled so that 2^19 is one full turn
	localparam ph_t ATAN_TABLE [18] = '{
		19'sd65536, 19'sd38688, 19'sd20442, 19'sd10377, 19'sd5208, 19'sd2607,
		19'sd1304, 19'sd652, 19'sd326, 19'sd163, 19'sd81, 19'sd41,
		19'sd20, 19'sd10, 19'sd5, 19'sd3, 19'sd1, 19'sd1
	};

endpackage

/* hw/cordic_if.sv */
`timescale 1ns/100ps

interface cordic_if;
	// Request side, operands valid only while req is high
	logic                   req;
	fdbk_pkg::cordic_mode_t mode;
	fdbk_pkg::iq_t          x;
	fdbk_pkg::iq_t          y;
	fdbk_pkg::ph_t          z;
	// Result side, valid while done is high
	logic                   done;
	fdbk_pkg::iq_t          res_x;  // Magnitude or I
	fdbk_pkg::iq_t          res_y;  // Q in rotation mode
	fdbk_pkg::ph_t          res_z;  // Phase in vectoring mode

	modport requester (output req, mode, x, y, z, input done, res_x, res_y, res_z);

	modport engine (input req, mode, x, y, z, output done, res_x, res_y, res_z);

endinterface

/* hw/cordic_engine.sv */
`timescale 1ns/100ps

module cordic_engine #(
	parameter int ITERATIONS = 16   // 12 to 18
) (
	input logic      clk,
	input logic      rst_n,
	cordic_if.engine cor
);
	localparam int W = 21;          // Three guard bits over iq_t

	fdbk_pkg::cordic_state_t state;
	fdbk_pkg::cordic_mode_t  mode;
	logic signed [W-1:0]     x, y;
	logic signed [W-1:0]     x_in, y_in;
	logic signed [W-1:0]     x_sh, y_sh;
	fdbk_pkg::ph_t           z;
	logic [4:0]              iter;
	logic                    left;  // Operand sits in the left half-plane
	logic                    neg;   // Rotate clockwise this step
	logic signed [W+17:0]    px, py;
	fdbk_pkg::ph_t           pz;
	logic                    prod_valid;

	// Round the Q0.17 product back to iq_t and saturate
	function automatic fdbk_pkg::iq_t sat_round(input logic signed [W+17:0] p);
		logic signed [W+17:0] r;
		r = (p + (1 <<< 16)) >>> 17;
		if (r > 39'sd131071)
			return 18'sh1ffff;
		else if (r < -39'sd131072)
			return 18'sh20000;
		return r[17:0];
	endfunction

	assign x_in = cor.x;            // Sign extend to working width
	assign y_in = cor.y;
	assign left = (cor.mode == fdbk_pkg::vectoring) ? cor.x[17] : (cor.z[18] ^ cor.z[17]);

	assign x_sh = x >>> iter;
	assign y_sh = y >>> iter;
	// Vectoring drives y to zero, rotation drives z to zero
	assign neg = (mode == fdbk_pkg::vectoring) ? ~y[W-1] : z[18];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= fdbk_pkg::idle;
			iter       <= '0;
			prod_valid <= 1'b0;
			cor.done   <= 1'b0;
		end else begin
			prod_valid <= (state == fdbk_pkg::scale);  // Product lands next cycle
			cor.done   <= prod_valid;
			case (state)
				fdbk_pkg::idle: if (cor.req) begin
					state <= fdbk_pkg::run;
					iter  <= '0;
				end
				fdbk_pkg::run: begin
					iter <= iter + 5'd1;
					if (iter == 5'(ITERATIONS - 1))
						state <= fdbk_pkg::scale;
				end
				default: state <= fdbk_pkg::idle;  // Scale lasts one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			fdbk_pkg::idle: if (cor.req) begin
				mode <= cor.mode;
				// Half-turn pre-rotation keeps the start angle within reach
				x <= left ? -x_in : x_in;
				y <= left ? -y_in : y_in;
				z <= left ? cor.z + fdbk_pkg::HALF_TURN : cor.z;
			end
			fdbk_pkg::run: begin
				if (neg) begin
					x <= x + y_sh;
					y <= y - x_sh;
					z <= z + fdbk_pkg::ATAN_TABLE[iter];
				end else begin
					x <= x - y_sh;
					y <= y + x_sh;
					z <= z - fdbk_pkg::ATAN_TABLE[iter];
				end
			end
			fdbk_pkg::scale: begin
				px <= x * fdbk_pkg::INV_GAIN;  // Remove CORDIC gain
				py <= y * fdbk_pkg::INV_GAIN;
				pz <= z;
			end
			default: ;
		endcase
		if (prod_valid) begin
			cor.res_x <= sat_round(px);
			cor.res_y <= sat_round(py);
			cor.res_z <= pz;
		end
	end

endmodule

/* hw/cordic_arbiter.sv */
`timescale 1ns/100ps

module cordic_arbiter (
	input logic         clk,
	input logic         rst_n,
	cordic_if.engine    req_a,  // From frame_capture
	cordic_if.engine    req_b,  // From mp_ctrl, higher priority
	cordic_if.requester eng
);
	logic                   pend_a, pend_b;
	logic                   busy;
	logic                   owner;  // 1 when req_b owns the running job
	logic                   grant_a, grant_b;
	fdbk_pkg::cordic_mode_t mode_a, mode_b;
	fdbk_pkg::iq_t          x_a, y_a, x_b, y_b;
	fdbk_pkg::ph_t          z_a, z_b;

	assign grant_b = !busy && pend_b;
	assign grant_a = !busy && pend_a && !pend_b;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend_a  <= 1'b0;
			pend_b  <= 1'b0;
			busy    <= 1'b0;
			owner   <= 1'b0;
			eng.req <= 1'b0;
		end else begin
			pend_a  <= (pend_a && !grant_a) || req_a.req;  // New request wins over clear
			pend_b  <= (pend_b && !grant_b) || req_b.req;
			eng.req <= grant_a || grant_b;
			if (grant_a || grant_b) begin
				busy  <= 1'b1;
				owner <= grant_b;
			end else if (eng.done) begin
				busy <= 1'b0;
			end
		end
	end

	// Pending operand slots and forwarding mux
	always_ff @(posedge clk) begin
		if (req_a.req) begin
			mode_a <= req_a.mode;
			x_a    <= req_a.x;
			y_a    <= req_a.y;
			z_a    <= req_a.z;
		end
		if (req_b.req) begin
			mode_b <= req_b.mode;
			x_b    <= req_b.x;
			y_b    <= req_b.y;
			z_b    <= req_b.z;
		end
		if (grant_b) begin
			eng.mode <= mode_b;
			eng.x    <= x_b;
			eng.y    <= y_b;
			eng.z    <= z_b;
		end else if (grant_a) begin
			eng.mode <= mode_a;
			eng.x    <= x_a;
			eng.y    <= y_a;
			eng.z    <= z_a;
		end
	end

	assign req_a.done  = eng.done && !owner;  // Only the owner sees done
	assign req_b.done  = eng.done && owner;
	assign req_a.res_x = eng.res_x;
	assign req_a.res_y = eng.res_y;
	assign req_a.res_z = eng.res_z;
	assign req_b.res_x = eng.res_x;
	assign req_b.res_y = eng.res_y;
	assign req_b.res_z = eng.res_z;

endmodule

/* hw/frame_capture.sv */
`timescale 1ns/100ps

module frame_capture (
	input logic          clk,
	input logic          rst_n,
	input logic          in_valid,
	input logic          in_iq,   // High on the I sample
	input fdbk_pkg::iq_t in_xy,
	cordic_if.requester  cor
);
	logic          have_i;        // Previous cycle carried an I sample
	logic          take_q;
	fdbk_pkg::iq_t i_hold;

	// Q pairs only with an I on the cycle just before
	assign take_q = in_valid && !in_iq && have_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			have_i  <= 1'b0;
			cor.req <= 1'b0;
		end else begin
			have_i  <= in_valid && in_iq;
			cor.req <= take_q;    // One cycle after Q
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_iq)
			i_hold <= in_xy;
		if (take_q) begin
			cor.x <= i_hold;
			cor.y <= in_xy;
		end
	end

	assign cor.mode = fdbk_pkg::vectoring;
	assign cor.z    = '0;           // Phase result starts from zero

endmodule

/* hw/mp_ctrl.sv */
`timescale 1ns/100ps

module mp_ctrl #(
	parameter int GAIN_SHIFT = 6
) (
	input logic            clk,
	input logic            rst_n,
	cordic_if.requester    cor_in,     // Capture bus, only done and results read
	cordic_if.requester    cor_out,    // Rotation request
	input logic            chirp_en,
	input fdbk_pkg::iq_t   chirp_amp,
	input fdbk_pkg::ph_t   chirp_ph,
	input fdbk_pkg::iq_t   set_mag,
	input fdbk_pkg::ph_t   set_ph,
	input fdbk_pkg::gain_t gain_mag,
	input fdbk_pkg::gain_t gain_ph,
	input fdbk_pkg::iq_t   lim_hi,
	input fdbk_pkg::iq_t   lim_lo,
	output fdbk_pkg::evt_t cmp_event
);
	logic signed [18:0] mag_err;
	logic signed [27:0] mag_prod;
	logic signed [28:0] mag_sum;       // Unclamped drive magnitude
	fdbk_pkg::ph_t      ph_err;
	logic signed [27:0] ph_prod;
	fdbk_pkg::ph_t      ph_sum;
	fdbk_pkg::iq_t      drv_mag;
	fdbk_pkg::evt_t     drv_evt;

	// Magnitude term, error kept one bit wider than iq_t
	assign mag_err  = set_mag - cor_in.res_x;
	assign mag_prod = mag_err * $signed({1'b0, gain_mag});
	assign mag_sum  = set_mag + (mag_prod >>> GAIN_SHIFT);

	// Phase term wraps modulo a full turn
	assign ph_err  = set_ph - cor_in.res_z;
	assign ph_prod = ph_err * $signed({1'b0, gain_ph});
	assign ph_sum  = set_ph + fdbk_pkg::ph_t'(ph_prod >>> GAIN_SHIFT);

	always_comb begin
		drv_evt = '0;
		if (mag_sum > lim_hi) begin
			drv_mag                  = lim_hi;
			drv_evt[fdbk_pkg::EVT_HI] = 1'b1;
		end else if (mag_sum < lim_lo) begin
			drv_mag                  = lim_lo;
			drv_evt[fdbk_pkg::EVT_LO] = 1'b1;
		end else begin
			drv_mag = fdbk_pkg::iq_t'(mag_sum);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cor_out.req <= 1'b0;
			cmp_event   <= '0;
		end else begin
			cor_out.req <= cor_in.done;   // Rotation one cycle after vectoring done
			if (cor_in.done)
				cmp_event <= chirp_en ? '0 : drv_evt;  // No flags in chirp
		end
	end

	always_ff @(posedge clk) begin
		if (cor_in.done) begin
			cor_out.x <= chirp_en ? chirp_amp : drv_mag;
			cor_out.z <= chirp_en ? chirp_ph : ph_sum;
		end
	end

	assign cor_out.y    = '0;
	assign cor_out.mode = fdbk_pkg::rotation;

endmodule

/* hw/drive_serializer.sv */
`timescale 1ns/100ps

module drive_serializer (
	input logic           clk,
	input logic           rst_n,
	cordic_if.requester   cor,        // Rotation bus, done side only
	output logic          out_valid,
	output logic          out_iq,     // High while out_xy carries I
	output fdbk_pkg::iq_t out_xy
);
	logic          second;            // Q cycle of the pair
	fdbk_pkg::iq_t q_hold;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			second    <= 1'b0;
			out_valid <= 1'b0;
			out_iq    <= 1'b0;
		end else begin
			second    <= cor.done;
			out_valid <= cor.done || second;  // Two-cycle pair
			out_iq    <= cor.done;
		end
	end

	always_ff @(posedge clk) begin
		if (cor.done) begin
			out_xy <= cor.res_x;          // I first
			q_hold <= cor.res_y;
		end else if (second) begin
			out_xy <= q_hold;
		end
	end

endmodule

/* hw/fdbk_top.sv */
`timescale 1ns/100ps

module fdbk_top #(
	parameter int ITERATIONS = 16,   // CORDIC iterations, 12 to 18
	parameter int GAIN_SHIFT = 6     // Downshift of gain products
) (
	input logic            clk,
	input logic            rst_n,
	input logic            in_valid,
	input logic            in_iq,
	input fdbk_pkg::iq_t   in_xy,
	input logic            chirp_en,
	input fdbk_pkg::iq_t   chirp_amp,
	input fdbk_pkg::ph_t   chirp_ph,
	input fdbk_pkg::iq_t   set_mag,
	input fdbk_pkg::ph_t   set_ph,
	input fdbk_pkg::gain_t gain_mag,
	input fdbk_pkg::gain_t gain_ph,
	input fdbk_pkg::iq_t   lim_hi,
	input fdbk_pkg::iq_t   lim_lo,
	output logic           out_valid,
	output logic           out_iq,
	output fdbk_pkg::iq_t  out_xy,
	output fdbk_pkg::evt_t cmp_event
);
	cordic_if cap_bus ();   // Capture to arbiter, vectoring
	cordic_if ctl_bus ();   // Controller to arbiter, rotation
	cordic_if eng_bus ();   // Arbiter to shared engine

	frame_capture frame_capture_inst (.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.in_iq(in_iq), .in_xy(in_xy), .cor(cap_bus));

	mp_ctrl #(.GAIN_SHIFT(GAIN_SHIFT)) mp_ctrl_inst (.clk(clk), .rst_n(rst_n),
		.cor_in(cap_bus), .cor_out(ctl_bus), .chirp_en(chirp_en), .chirp_amp(chirp_amp),
		.chirp_ph(chirp_ph), .set_mag(set_mag), .set_ph(set_ph), .gain_mag(gain_mag),
		.gain_ph(gain_ph), .lim_hi(lim_hi), .lim_lo(lim_lo), .cmp_event(cmp_event));

	cordic_arbiter cordic_arbiter_inst (.clk(clk), .rst_n(rst_n), .req_a(cap_bus),
		.req_b(ctl_bus), .eng(eng_bus));

	cordic_engine #(.ITERATIONS(ITERATIONS)) cordic_engine_inst (.clk(clk), .rst_n(rst_n),
		.cor(eng_bus));

	// Listens to the rotation result on the controller bus
	drive_serializer drive_serializer_inst (.clk(clk), .rst_n(rst_n), .cor(ctl_bus),
		.out_valid(out_valid), .out_iq(out_iq), .out_xy(out_xy));

endmodule

/* testbench/tb_fdbk.sv */
`timescale 1ns/100ps

module tb_fdbk;
	localparam int  ITERATIONS = 16;
	localparam int  GAIN_SHIFT = 6;
	localparam int  N_ZERO     = 8;       // Frames per test
	localparam int  N_PROP     = 8;
	localparam int  N_LIMIT    = 4;       // Per limit side
	localparam int  N_CHIRP    = 6;
	localparam int  N_FRAMES   = N_ZERO + N_PROP + 2 * N_LIMIT + N_CHIRP + 1;
	localparam real WATCHDOG_NS = N_FRAMES * 64 * 100.0 + 10000.0;
	localparam real PI     = 3.14159265358979;
	localparam real PH_LSB = 2.0 * PI / 524288.0;  // Radians per phase LSB
	localparam fdbk_pkg::iq_t LIM_MAX = 18'sh1ffff;
	localparam fdbk_pkg::iq_t LIM_MIN = 18'sh20000;

	typedef struct packed {
		fdbk_pkg::iq_t  i;
		fdbk_pkg::iq_t  q;
		fdbk_pkg::evt_t evt;
	} expect_t;

	logic clk, rst_n, in_valid, in_iq, chirp_en;
	fdbk_pkg::iq_t   in_xy, chirp_amp, set_mag, lim_hi, lim_lo;
	fdbk_pkg::ph_t   chirp_ph, set_ph;
	fdbk_pkg::gain_t gain_mag, gain_ph;
	logic            out_valid, out_iq;
	fdbk_pkg::iq_t   out_xy;
	fdbk_pkg::evt_t  cmp_event;

	logic [31:0] lfsr = 32'h2239;
	expect_t     exp_q[$];
	string       name_q[$];
	expect_t     cur;
	string       cur_name;
	logic        in_pair = 1'b0;      // Waiting for the Q cycle

	fdbk_top #(.ITERATIONS(ITERATIONS), .GAIN_SHIFT(GAIN_SHIFT)) fdbk_top_inst (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_iq(in_iq), .in_xy(in_xy),
		.chirp_en(chirp_en), .chirp_amp(chirp_amp), .chirp_ph(chirp_ph),
		.set_mag(set_mag), .set_ph(set_ph), .gain_mag(gain_mag), .gain_ph(gain_ph),
		.lim_hi(lim_hi), .lim_lo(lim_lo), .out_valid(out_valid), .out_iq(out_iq),
		.out_xy(out_xy), .cmp_event(cmp_event));

	always #50 clk = ~clk;              // 100 ns period

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);       // One step per bit
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic real rand_real(input real lo, input real hi);
		return lo + (hi - lo) * real'(rand_bits(16)) / 65536.0;
	endfunction

	function automatic fdbk_pkg::iq_t round_iq(input real v);
		return fdbk_pkg::iq_t'($rtoi($floor(v + 0.5)));
	endfunction

	function automatic real wrap_turn(input real p);
		real w;
		w = p;
		while (w >= 262144.0) w = w - 524288.0;
		while (w < -262144.0) w = w + 524288.0;
		return w;
	endfunction

	// Polar controller in real math, phases in LSB
	function automatic expect_t ref_model(input fdbk_pkg::iq_t i_s, input fdbk_pkg::iq_t q_s);
		real     meas_mag, meas_ph, drv_mag, drv_ph;
		expect_t e;
		meas_mag = $sqrt(real'(i_s) * real'(i_s) + real'(q_s) * real'(q_s));
		meas_ph  = $atan2(real'(q_s), real'(i_s)) / PH_LSB;
		e.evt    = '0;
		if (chirp_en) begin
			drv_mag = real'(chirp_amp);   // Controller bypassed
			drv_ph  = real'(chirp_ph);
		end else begin
			drv_mag = real'(set_mag) + (real'(set_mag) - meas_mag) * real'(gain_mag)
				/ (2.0 ** GAIN_SHIFT);
			drv_ph  = real'(set_ph) + wrap_turn(real'(set_ph) - meas_ph) * real'(gain_ph)
				/ (2.0 ** GAIN_SHIFT);
			if (drv_mag > real'(lim_hi)) begin
				drv_mag  = real'(lim_hi);
				e.evt[0] = 1'b1;
			end else if (drv_mag < real'(lim_lo)) begin
				drv_mag  = real'(lim_lo);
				e.evt[1] = 1'b1;
			end
		end
		e.i = round_iq(drv_mag * $cos(drv_ph * PH_LSB));
		e.q = round_iq(drv_mag * $sin(drv_ph * PH_LSB));
		return e;
	endfunction

	task automatic fail_stop();
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at first failure");
	endtask

	task automatic check_iq(input string name, input fdbk_pkg::iq_t exp_v,
		input fdbk_pkg::iq_t act_v);
		int diff;
		diff = int'(act_v) - int'(exp_v);
		if (diff > 12 || diff < -12) begin  // CORDIC error budget
			$display("ERROR %s: expected %0d, actual %0d", name, exp_v, act_v);
			fail_stop();
		end
	endtask

	task automatic check_evt(input string name, input fdbk_pkg::evt_t exp_v,
		input fdbk_pkg::evt_t act_v);
		if (act_v !== exp_v) begin
			$display("ERROR %s: expected %0d, actual %0d", name, exp_v, act_v);
			fail_stop();
		end
	endtask

	// One I/Q pair, then idle to a 64-cycle frame
	task automatic drive_frame(input string name, input real in_mag, input real in_ang);
		fdbk_pkg::iq_t i_s, q_s;
		i_s = round_iq(in_mag * $cos(in_ang));
		q_s = round_iq(in_mag * $sin(in_ang));
		exp_q.push_back(ref_model(i_s, q_s));
		name_q.push_back(name);
		@(negedge clk);
		in_valid = 1'b1;
		in_iq    = 1'b1;
		in_xy    = i_s;
		@(negedge clk);
		in_iq = 1'b0;
		in_xy = q_s;
		@(negedge clk);
		in_valid = 1'b0;
		in_xy    = '0;
		repeat (61) @(negedge clk);
	endtask

	// Input near the setpoint so the phase error stays far from a half turn
	task automatic track_frame(input string name, input int lim_mode);
		set_mag  = round_iq(rand_real(30000.0, 50000.0));
		set_ph   = fdbk_pkg::ph_t'(rand_bits(19));
		gain_mag = fdbk_pkg::gain_t'(rand_bits(5) + 1);
		gain_ph  = fdbk_pkg::gain_t'(rand_bits(5) + 1);
		lim_hi   = (lim_mode == 1) ? set_mag - 18'sd2000 : LIM_MAX;
		lim_lo   = (lim_mode == 2) ? set_mag + 18'sd2000 : ((lim_mode == 1) ? '0 : LIM_MIN);
		drive_frame(name, real'(set_mag) + rand_real(-1000.0, 1000.0),
			real'(set_ph) * PH_LSB + rand_real(-0.3, 0.3));
	endtask

	// Samples outputs on the falling edge, away from the DUT's rising edge
	always @(negedge clk) begin
		if (in_pair) begin
			if (out_valid !== 1'b1 || out_iq !== 1'b0) begin
				$display("Output pair ended after one cycle or repeated its I cycle");
				fail_stop();
			end
			check_iq({cur_name, " Q"}, cur.q, out_xy);
			in_pair = 1'b0;
		end else if (out_valid !== 1'b0) begin
			if (exp_q.size() == 0) begin
				$display("Output appeared while no frame was pending");
				fail_stop();
			end
			if (out_iq !== 1'b1) begin
				$display("Output pair did not start with the I cycle");
				fail_stop();
			end
			cur      = exp_q.pop_front();
			cur_name = name_q.pop_front();
			check_iq({cur_name, " I"}, cur.i, out_xy);
			check_evt({cur_name, " event"}, cur.evt, cmp_event);
			in_pair = 1'b1;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout, the expected outputs did not arrive");
		fail_stop();
	end

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		in_iq     = 1'b0;
		in_xy     = '0;
		chirp_en  = 1'b0;
		chirp_amp = '0;
		chirp_ph  = '0;
		set_mag   = '0;
		set_ph    = '0;
		gain_mag  = '0;
		gain_ph   = '0;
		lim_hi    = LIM_MAX;
		lim_lo    = LIM_MIN;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);    // Quiet cycles right after reset
		for (int k = 0; k < N_ZERO; k++) begin
			set_mag = round_iq(rand_real(20000.0, 60000.0));
			set_ph  = fdbk_pkg::ph_t'(rand_bits(19));
			drive_frame("zero_gain", rand_real(20000.0, 60000.0),
				(k % 4) * PI / 2.0 + rand_real(0.1, 1.4));  // All four quadrants
		end
		for (int k = 0; k < N_PROP; k++)
			track_frame("prop_gain", 0);
		for (int k = 0; k < N_LIMIT; k++)
			track_frame("limit_hi", 1);
		for (int k = 0; k < N_LIMIT; k++)
			track_frame("limit_lo", 2);
		chirp_en = 1'b1;
		for (int k = 0; k < N_CHIRP; k++) begin
			chirp_amp = round_iq(rand_real(10000.0, 60000.0));
			chirp_ph  = fdbk_pkg::ph_t'(rand_bits(19));
			drive_frame("chirp", rand_real(20000.0, 60000.0), rand_real(-PI, PI));
		end
		chirp_en = 1'b0;
		// Lone Q sample must be dropped
		@(negedge clk);
		in_valid = 1'b1;
		in_iq    = 1'b0;
		in_xy    = 18'sd12345;
		@(negedge clk);
		in_valid = 1'b0;
		in_xy    = '0;
		repeat (62) @(negedge clk);
		while (exp_q.size() != 0 || in_pair)
			@(negedge clk);
		repeat (16) @(negedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* build.f */
hw/fdbk_pkg.sv
hw/cordic_if.sv
hw/cordic_engine.sv
hw/cordic_arbiter.sv
hw/frame_capture.sv
hw/mp_ctrl.sv
hw/drive_serializer.sv
hw/fdbk_top.sv
testbench/tb_fdbk.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_fdbk
FILELIST  = build.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
